//--- include/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register counts of the rename stage.
`define RENAME_ARCH_REGS      32
`define RENAME_PHYS_REGS      160
`define RENAME_FL_DEPTH       (`RENAME_PHYS_REGS - `RENAME_ARCH_REGS)

`define RENAME_TAG_W          8
`define RENAME_CKPT_PAGES     8

// tags that never come out of the free list.
`define RENAME_NULL_TAG       8'd254
`define RENAME_NO_DEST_TAG    8'd255

// RISC-V major opcodes seen by the decoder.
`define RENAME_OPCODE_NONE    7'b0000000
`define RENAME_OPCODE_LOAD    7'b0000011
`define RENAME_OPCODE_OP_IMM  7'b0010011
`define RENAME_OPCODE_AUIPC   7'b0010111
`define RENAME_OPCODE_STORE   7'b0100011
`define RENAME_OPCODE_OP      7'b0110011
`define RENAME_OPCODE_LUI     7'b0110111
`define RENAME_OPCODE_BRANCH  7'b1100011
`define RENAME_OPCODE_JALR    7'b1100111
`define RENAME_OPCODE_JAL     7'b1101111

`endif

//--- hw/rename_pkg.sv
`include "rename_consts.svh"

package rename_pkg;

    typedef logic [`RENAME_TAG_W-1:0] phys_tag_t;
    typedef logic [$clog2(`RENAME_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`RENAME_CKPT_PAGES)-1:0] ckpt_id_t;

    // index into the free list plus one wrap bit on top.
    typedef logic [$clog2(`RENAME_FL_DEPTH):0] fl_ptr_t;

    typedef struct packed {
        logic      valid;
        logic [6:0] opcode;
        arch_reg_t rs1;
        arch_reg_t rs2;
        arch_reg_t rd;
        logic      save;       // branch asks for a checkpoint.
        ckpt_id_t  save_page;
    } rename_req_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
        phys_tag_t dest_tag;
        phys_tag_t old_dest_tag;  // mapping of rd before this rename.
    } rename_resp_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } release_t;

    typedef struct packed {
        logic     valid;
        ckpt_id_t page;
    } restore_t;

    typedef struct packed {
        logic uses_rs1;
        logic uses_rs2;
        logic writes_rd;
    } operand_usage_t;

endpackage

//--- hw/operand_usage_decoder.sv
`include "rename_consts.svh"

module operand_usage_decoder (
    input  logic [6:0]                 opcode,
    output rename_pkg::operand_usage_t usage
);

    always_comb begin
        // most opcodes read both sources and write rd.
        usage.uses_rs1  = 1'b1;
        usage.uses_rs2  = 1'b1;
        usage.writes_rd = 1'b1;

        case (opcode)
            `RENAME_OPCODE_JALR,
            `RENAME_OPCODE_LOAD,
            `RENAME_OPCODE_OP_IMM: begin
                usage.uses_rs2 = 1'b0;  // the immediate takes the rs2 slot.
            end
            `RENAME_OPCODE_LUI,
            `RENAME_OPCODE_AUIPC,
            `RENAME_OPCODE_JAL: begin
                usage.uses_rs1 = 1'b0;
                usage.uses_rs2 = 1'b0;
            end
            `RENAME_OPCODE_BRANCH,
            `RENAME_OPCODE_STORE: begin
                usage.writes_rd = 1'b0;  // compare or address only, nothing is written back.
            end
            `RENAME_OPCODE_NONE: begin
                // An all-zero word is a bubble and must not consume a tag.
                usage.writes_rd = 1'b0;
            end
            default: begin
                usage.writes_rd = 1'b1;
            end
        endcase
    end

endmodule

//--- hw/free_list.sv
`include "rename_consts.svh"

module free_list (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 alloc,
    output rename_pkg::phys_tag_t head_tag,
    input  rename_pkg::release_t release_in,
    output rename_pkg::fl_ptr_t  head_ptr,
    input  logic                 restore_valid,
    input  rename_pkg::fl_ptr_t  restore_head,
    output logic [7:0]           free_count
);

    localparam int IDX_W = $clog2(`RENAME_FL_DEPTH);

    rename_pkg::phys_tag_t entries [`RENAME_FL_DEPTH];
    rename_pkg::fl_ptr_t   rd_ptr;
    rename_pkg::fl_ptr_t   wr_ptr;

    assign head_tag = entries[rd_ptr[IDX_W-1:0]];  // next tag is always on view.
    assign head_ptr = rd_ptr;

    // The wrap bits make a full list read as depth and not as zero.
    assign free_count = wr_ptr - rd_ptr;

    // Read side. A restore moves the head back, so the tags taken since the
    // checkpoint are handed out again. A restore beats an allocate.
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (restore_valid) begin
            rd_ptr <= restore_head;
        end else if (alloc) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Write side. Released tags go in behind everything already waiting.
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= rename_pkg::fl_ptr_t'(`RENAME_FL_DEPTH);  // list starts full.
        end else if (release_in.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RENAME_FL_DEPTH; i++) begin
                // tags above the architectural range, in ascending order.
                entries[i] <= rename_pkg::phys_tag_t'(`RENAME_ARCH_REGS + i);
            end
        end else if (release_in.valid) begin
            entries[wr_ptr[IDX_W-1:0]] <= release_in.tag;
        end
    end

endmodule

//--- hw/map_checkpoint_store.sv
`include "rename_consts.svh"

module map_checkpoint_store (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            save_valid,
    input  rename_pkg::ckpt_id_t                            save_page,
    input  rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0]   save_map,
    input  rename_pkg::fl_ptr_t                             save_head,
    input  rename_pkg::ckpt_id_t                            restore_page,
    output rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0]   restore_map,
    output rename_pkg::fl_ptr_t                             restore_head
);

    // one map snapshot and one free-list head per in-flight branch.
    rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0] page_map  [`RENAME_CKPT_PAGES];
    rename_pkg::fl_ptr_t                           page_head [`RENAME_CKPT_PAGES];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < `RENAME_CKPT_PAGES; p++) begin
                page_map[p]  <= '0;
                page_head[p] <= '0;
            end
        end else if (save_valid) begin
            page_map[save_page]  <= save_map;   // whole map in one edge.
            page_head[save_page] <= save_head;
        end
    end

    // The read port is combinational so the restore lands at the very next edge.
    assign restore_map  = page_map[restore_page];
    assign restore_head = page_head[restore_page];

endmodule

//--- hw/register_alias_table.sv
`include "rename_consts.svh"

module register_alias_table (
    input  logic                                            clk,
    input  logic                                            reset,
    input  rename_pkg::rename_req_t                         req,
    input  rename_pkg::operand_usage_t                      usage,
    input  rename_pkg::restore_t                            restore,
    input  rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0]   restore_map,
    input  rename_pkg::phys_tag_t                           new_tag,
    output logic                                            alloc,
    output rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0]   snapshot,
    output rename_pkg::rename_resp_t                        resp
);

    rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0] map_q;

    logic                  accept;    // request survives a restore in the same cycle.
    logic                  has_dest;
    logic                  resp_valid;
    rename_pkg::phys_tag_t src1_q;
    rename_pkg::phys_tag_t src2_q;
    rename_pkg::phys_tag_t dest_q;
    rename_pkg::phys_tag_t old_dest_q;

    assign accept   = req.valid && !restore.valid;
    assign has_dest = usage.writes_rd && (req.rd != '0);  // x0 is never renamed.
    assign alloc    = accept && has_dest;

    // The checkpoint sees the map before this request's own remap.
    assign snapshot = map_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `RENAME_ARCH_REGS; k++) begin
                map_q[k] <= rename_pkg::phys_tag_t'(k);  // identity map.
            end
        end else if (restore.valid) begin
            map_q <= restore_map;  // mispredict throws away the speculative map.
        end else if (alloc) begin
            map_q[req.rd] <= new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;  // fixed latency of one cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            src1_q <= usage.uses_rs1 ? map_q[req.rs1] : `RENAME_NULL_TAG;
            src2_q <= usage.uses_rs2 ? map_q[req.rs2] : `RENAME_NULL_TAG;
            if (has_dest) begin
                dest_q     <= new_tag;
                old_dest_q <= map_q[req.rd];  // freed later at commit.
            end else begin
                dest_q     <= `RENAME_NO_DEST_TAG;
                old_dest_q <= `RENAME_NO_DEST_TAG;
            end
        end
    end

    assign resp = '{
        valid:        resp_valid,
        src1_tag:     src1_q,
        src2_tag:     src2_q,
        dest_tag:     dest_q,
        old_dest_tag: old_dest_q
    };

endmodule

//--- hw/rename_unit.sv
`include "rename_consts.svh"

module rename_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  rename_pkg::rename_req_t  req,
    input  rename_pkg::release_t     release_in,
    input  rename_pkg::restore_t     restore,
    output rename_pkg::rename_resp_t resp,
    output logic [7:0]               free_count
);

    rename_pkg::operand_usage_t                    usage;
    logic                                          alloc;
    logic                                          save_valid;
    rename_pkg::phys_tag_t                         head_tag;
    rename_pkg::fl_ptr_t                           head_ptr;
    rename_pkg::fl_ptr_t                           restore_head;
    rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0] snapshot;
    rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0] restore_map;

    // A request dropped by a restore does not leave a checkpoint behind.
    assign save_valid = req.valid && req.save && !restore.valid;

    operand_usage_decoder u_decoder (
        .opcode (req.opcode),
        .usage  (usage)
    );

    free_list u_free_list (
        .clk           (clk),
        .reset         (reset),
        .alloc         (alloc),
        .head_tag      (head_tag),
        .release_in    (release_in),
        .head_ptr      (head_ptr),
        .restore_valid (restore.valid),
        .restore_head  (restore_head),
        .free_count    (free_count)
    );

    map_checkpoint_store u_ckpt_store (
        .clk          (clk),
        .reset        (reset),
        .save_valid   (save_valid),
        .save_page    (req.save_page),
        .save_map     (snapshot),
        .save_head    (head_ptr),
        .restore_page (restore.page),
        .restore_map  (restore_map),
        .restore_head (restore_head)
    );

    register_alias_table u_rat (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .usage       (usage),
        .restore     (restore),
        .restore_map (restore_map),
        .new_tag     (head_tag),
        .alloc       (alloc),
        .snapshot    (snapshot),
        .resp        (resp)
    );

endmodule

//--- verification/rename_properties.sv
`include "rename_consts.svh"

module rename_properties (
    input logic                     clk,
    input logic                     reset,
    input rename_pkg::rename_req_t  req,
    input rename_pkg::restore_t     restore,
    input rename_pkg::rename_resp_t resp,
    input logic [7:0]               free_count,
    input logic                     alloc
);

    logic accepted;

    assign accepted = req.valid && !restore.valid;  // a restore drops the request.

    no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (reset) alloc |-> (free_count != 8'd0)
    ) else $error("a tag was taken while the free list was empty");

    resp_after_accept: assert property (
        @(posedge clk) disable iff (reset) accepted |=> resp.valid
    ) else $error("an accepted request gave no response one cycle later");

    no_resp_without_accept: assert property (
        @(posedge clk) disable iff (reset) !accepted |=> !resp.valid
    ) else $error("a response appeared without an accepted request");

    dest_never_null: assert property (
        @(posedge clk) disable iff (reset) resp.valid |-> (resp.dest_tag != `RENAME_NULL_TAG)
    ) else $error("a response carried the null tag as its destination");

endmodule

bind rename_unit rename_properties i_rename_properties (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .restore    (restore),
    .resp       (resp),
    .free_count (free_count),
    .alloc      (alloc)
);

//--- verification/rename_tb.sv
`include "rename_consts.svh"

module rename_tb;

    localparam int N_RANDOM       = 3000;
    localparam int PLANNED_CYCLES = 16 + 64 + N_RANDOM;

    // one opcode per class, the last one falls in the default class.
    localparam logic [6:0] OPCODES [11] = '{
        `RENAME_OPCODE_NONE, `RENAME_OPCODE_LOAD, `RENAME_OPCODE_OP_IMM,
        `RENAME_OPCODE_AUIPC, `RENAME_OPCODE_STORE, `RENAME_OPCODE_OP,
        `RENAME_OPCODE_LUI, `RENAME_OPCODE_BRANCH, `RENAME_OPCODE_JALR,
        `RENAME_OPCODE_JAL, 7'b0101111
    };

    logic                     clk;
    logic                     reset;
    rename_pkg::rename_req_t  req;
    rename_pkg::release_t     release_in;
    rename_pkg::restore_t     restore;
    rename_pkg::rename_resp_t resp;
    logic [7:0]               free_count;

    rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0] ref_map;
    rename_pkg::phys_tag_t [`RENAME_ARCH_REGS-1:0] ckpt_map [`RENAME_CKPT_PAGES];
    int                       ckpt_len [`RENAME_CKPT_PAGES];  // allocations done at the save.
    int                       ckpt_seq [`RENAME_CKPT_PAGES];
    bit                       ckpt_ok  [`RENAME_CKPT_PAGES];
    int                       save_seq;
    rename_pkg::phys_tag_t    free_q [$];
    rename_pkg::phys_tag_t    alloc_hist [$];
    rename_pkg::phys_tag_t    retired_q [$];  // old mappings waiting to be released.
    rename_pkg::rename_resp_t exp_resp_q [$];
    logic [7:0]               exp_count_q [$];
    logic [31:0]              lfsr_state;

    rename_unit i_rename_unit (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .release_in (release_in),
        .restore    (restore),
        .resp       (resp),
        .free_count (free_count)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic void init_model();
        free_q.delete();
        alloc_hist.delete();
        retired_q.delete();
        for (int k = 0; k < `RENAME_ARCH_REGS; k++) begin
            ref_map[k] = rename_pkg::phys_tag_t'(k);
        end
        for (int t = 0; t < `RENAME_FL_DEPTH; t++) begin
            free_q.push_back(rename_pkg::phys_tag_t'(`RENAME_ARCH_REGS + t));
        end
        for (int p = 0; p < `RENAME_CKPT_PAGES; p++) begin
            ckpt_ok[p]  = 1'b0;
            ckpt_len[p] = 0;
            ckpt_seq[p] = 0;
        end
        save_seq = 0;
    endfunction

    // Expected response of one cycle; the model state moves as the DUT will at the next edge.
    function automatic rename_pkg::rename_resp_t reference_rename(
        input rename_pkg::rename_req_t r,
        input rename_pkg::release_t    rel,
        input rename_pkg::restore_t    rst
    );
        rename_pkg::rename_resp_t e;
        logic                     reads1;
        logic                     reads2;
        logic                     writes;
        e      = '0;
        reads1 = 1'b1;
        reads2 = 1'b1;
        writes = 1'b1;
        case (r.opcode)
            `RENAME_OPCODE_LUI, `RENAME_OPCODE_AUIPC, `RENAME_OPCODE_JAL: begin
                reads1 = 1'b0;
                reads2 = 1'b0;
            end
            `RENAME_OPCODE_JALR, `RENAME_OPCODE_LOAD, `RENAME_OPCODE_OP_IMM: reads2 = 1'b0;
            `RENAME_OPCODE_BRANCH, `RENAME_OPCODE_STORE, `RENAME_OPCODE_NONE: writes = 1'b0;
            default: ;
        endcase
        if (rst.valid) begin
            ref_map = ckpt_map[rst.page];
            // Tags taken since the save go back to the front, oldest first.
            while (alloc_hist.size() > ckpt_len[rst.page]) begin
                free_q.push_front(alloc_hist.pop_back());
            end
            for (int p = 0; p < `RENAME_CKPT_PAGES; p++) begin
                if (ckpt_seq[p] > ckpt_seq[rst.page]) begin
                    ckpt_ok[p] = 1'b0;  // younger branches are squashed.
                end
            end
        end else if (r.valid) begin
            if (r.save) begin
                save_seq++;
                ckpt_map[r.save_page] = ref_map;
                ckpt_len[r.save_page] = alloc_hist.size();
                ckpt_seq[r.save_page] = save_seq;
                ckpt_ok[r.save_page]  = 1'b1;
            end
            e.valid    = 1'b1;
            e.src1_tag = reads1 ? ref_map[r.rs1] : `RENAME_NULL_TAG;
            e.src2_tag = reads2 ? ref_map[r.rs2] : `RENAME_NULL_TAG;
            if (writes && (r.rd != '0)) begin
                e.dest_tag     = free_q.pop_front();
                e.old_dest_tag = ref_map[r.rd];
                ref_map[r.rd]  = e.dest_tag;
                alloc_hist.push_back(e.dest_tag);
            end else begin
                e.dest_tag     = `RENAME_NO_DEST_TAG;
                e.old_dest_tag = `RENAME_NO_DEST_TAG;
            end
        end
        if (rel.valid) begin
            free_q.push_back(rel.tag);
        end
        return e;
    endfunction

    // Slots of the free list that a live checkpoint may still hand out again.
    function automatic int pinned_tags();
        int low;
        low = alloc_hist.size();
        for (int p = 0; p < `RENAME_CKPT_PAGES; p++) begin
            if (ckpt_ok[p] && (ckpt_len[p] < low)) begin
                low = ckpt_len[p];
            end
        end
        return alloc_hist.size() - low;
    endfunction

    function automatic rename_pkg::rename_req_t make_req(
        input logic [6:0] opcode,
        input int         rs1,
        input int         rs2,
        input int         rd,
        input logic       save,
        input int         page
    );
        rename_pkg::rename_req_t r;
        r.valid     = 1'b1;
        r.opcode    = opcode;
        r.rs1       = rename_pkg::arch_reg_t'(rs1);
        r.rs2       = rename_pkg::arch_reg_t'(rs2);
        r.rd        = rename_pkg::arch_reg_t'(rd);
        r.save      = save;
        r.save_page = rename_pkg::ckpt_id_t'(page);
        return r;
    endfunction

    function automatic rename_pkg::restore_t make_restore(input int page);
        rename_pkg::restore_t rst;
        rst.valid = 1'b1;
        rst.page  = rename_pkg::ckpt_id_t'(page);
        return rst;
    endfunction

    function automatic rename_pkg::release_t make_release(input int tag);
        rename_pkg::release_t rel;
        rel.valid = 1'b1;
        rel.tag   = rename_pkg::phys_tag_t'(tag);
        return rel;
    endfunction

    task automatic drive_cycle(
        input rename_pkg::rename_req_t r,
        input rename_pkg::release_t    rel,
        input rename_pkg::restore_t    rst
    );
        rename_pkg::rename_resp_t e;
        @(posedge clk);
        req        <= r;
        release_in <= rel;
        restore    <= rst;
        e = reference_rename(r, rel, rst);
        if (e.valid && (e.dest_tag != `RENAME_NO_DEST_TAG)) begin
            retired_q.push_back(e.old_dest_tag);
        end
        exp_resp_q.push_back(e);
        exp_count_q.push_back(8'(free_q.size()));
    endtask

    task automatic random_cycle();
        rename_pkg::rename_req_t r;
        rename_pkg::release_t    rel;
        rename_pkg::restore_t    rst;
        int                      live [$];
        int                      idx;
        r   = '0;
        rel = '0;
        rst = '0;
        for (int p = 0; p < `RENAME_CKPT_PAGES; p++) begin
            if (ckpt_ok[p]) begin
                live.push_back(p);
            end
        end
        if ((random_bits(4) == 0) && (live.size() > 0)) begin
            rst = make_restore(live[random_bits(3) % live.size()]);  // mispredict.
        end
        if (random_bits(2) != 0) begin
            idx = random_bits(4) % 11;
            r = make_req(OPCODES[idx], random_bits(5), random_bits(5), random_bits(5), 1'b0, 0);
            if (r.opcode == `RENAME_OPCODE_BRANCH) begin
                r.save      = 1'(random_bits(1));
                r.save_page = rename_pkg::ckpt_id_t'(random_bits(3));
            end
            if (free_q.size() == 0) begin
                r.rd = '0;
            end
        end
        if (random_bits(1) && (retired_q.size() > 0)
                && (free_q.size() + pinned_tags() < `RENAME_FL_DEPTH)) begin
            rel = make_release(retired_q.pop_front());
        end
        if (random_bits(3) == 0) begin
            ckpt_ok[random_bits(3)] = 1'b0;  // a branch resolved as predicted.
        end
        drive_cycle(r, rel, rst);
    endtask

    task automatic check_resp(
        input rename_pkg::rename_resp_t got,
        input rename_pkg::rename_resp_t exp
    );
        if ((got.valid !== exp.valid) || (exp.valid && (got !== exp))) begin
            $display("MISMATCH at time %0t: response v=%0b src1=%0d src2=%0d dest=%0d old=%0d",
                     $time, got.valid, got.src1_tag, got.src2_tag, got.dest_tag,
                     got.old_dest_tag);
            $display("    expected v=%0b src1=%0d src2=%0d dest=%0d old=%0d", exp.valid,
                     exp.src1_tag, exp.src2_tag, exp.dest_tag, exp.old_dest_tag);
            $display("Simulation FAILED");
            $fatal(1, "rename response differs from the reference model");
        end
    endtask

    task automatic check_free_count(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at time %0t: free_count is %0d, expected %0d", $time, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "free count differs from the reference model");
        end
    endtask

    // Outputs are settled at the falling edge; the front entry belongs to the last edge.
    always @(negedge clk) begin : compare_outputs
        rename_pkg::rename_resp_t exp_resp;
        logic [7:0]               exp_count;
        if (exp_resp_q.size() > 1) begin
            exp_resp  = exp_resp_q.pop_front();
            exp_count = exp_count_q.pop_front();
            check_resp(resp, exp_resp);
            check_free_count(free_count, exp_count);
        end
    end

    initial begin
        #((PLANNED_CYCLES + 100) * 20);
        $display("Timeout: the run did not finish within the planned number of cycles.");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        req        = '0;
        release_in = '0;
        restore    = '0;
        lfsr_state = 32'h7b11;
        init_model();
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // identity map, x0 destination takes no tag.
        for (int i = 0; i < `RENAME_ARCH_REGS; i++) begin
            drive_cycle(make_req(`RENAME_OPCODE_OP, i, i, 0, 1'b0, 0), '0, '0);
        end
        for (int c = 0; c < 11; c++) begin
            drive_cycle(make_req(OPCODES[c], 3, 4, 7, 1'b0, 0), '0, '0);
        end
        // the oldest retired mapping is x7's own tag 7.
        drive_cycle(make_req(`RENAME_OPCODE_OP, 7, 7, 7, 1'b0, 0),
                    make_release(retired_q.pop_front()), '0);

        // save, rename past it, then restore while a request is dropped.
        drive_cycle(make_req(`RENAME_OPCODE_BRANCH, 1, 2, 0, 1'b1, 2), '0, '0);
        drive_cycle(make_req(`RENAME_OPCODE_OP, 1, 2, 5, 1'b0, 0), '0, '0);
        drive_cycle(make_req(`RENAME_OPCODE_OP_IMM, 5, 0, 6, 1'b0, 0), '0, '0);
        drive_cycle(make_req(`RENAME_OPCODE_OP, 5, 6, 8, 1'b0, 0), '0, make_restore(2));
        drive_cycle(make_req(`RENAME_OPCODE_OP, 5, 6, 9, 1'b0, 0), '0, '0);

        repeat (N_RANDOM) random_cycle();
        repeat (2) drive_cycle('0, '0, '0);
        @(negedge clk);
        @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- project.f
+incdir+include
hw/rename_pkg.sv
hw/operand_usage_decoder.sv
hw/free_list.sv
hw/map_checkpoint_store.sv
hw/register_alias_table.sv
hw/rename_unit.sv
verification/rename_properties.sv
verification/rename_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module rename_tb -o rename_sim

# The simulator stops with an error status on a failed check, so keep going to the search.
out=$(./obj_dir/rename_sim 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^Simulation PASSED$"
